//--- pibus_input.txt
# count req(m0 m1) lock opc ack addr | expected gnt(m0 m1) sel(3..0) tout
# count and ack decimal (1 wait, 2 ready, 3 error), opc and addr hex, the rest binary
# outputs are checked one ns before the edge that samples this line's inputs
# idle after reset
3 00 0 0 0 00000000 00 0000 0
# master 1 alone, read from slave 1, ready with no request pending
1 01 0 0 0 10000000 00 0000 0
1 00 0 1 0 10000000 01 0000 0
1 00 0 1 2 10000000 00 0010 0
2 00 0 0 0 00000000 00 0000 0
# both masters request, grant alternates from master 0
1 11 0 0 0 00000000 00 0000 0
1 11 0 0 0 00000000 10 0000 0
1 11 0 0 0 00000000 00 0000 0
1 11 0 0 0 00000000 01 0000 0
1 11 0 0 0 00000000 00 0000 0
1 11 0 0 0 00000000 10 0000 0
1 11 0 0 0 00000000 00 0000 0
1 11 0 0 0 00000000 01 0000 0
2 00 0 0 0 00000000 00 0000 0
# locked nop holds addr, locked transfer to slave 2 overlaps, back to addr
1 10 0 0 0 00000000 00 0000 0
1 00 1 0 0 20000000 10 0000 0
2 00 1 0 0 20000000 00 0000 0
1 00 1 1 2 20000000 00 0000 0
1 00 1 0 2 20000000 00 0100 0
1 00 0 1 0 30000000 00 0000 0
# slave error in data phase
1 00 0 1 3 30000000 00 0000 0
1 00 0 0 0 00000000 00 0000 1
1 00 0 0 0 00000000 00 0000 0
# held wait in data, watchdog fires 255 cycles after entry
1 01 0 0 0 00000000 00 0000 0
1 00 0 2 1 00000000 01 0000 0
1 00 0 2 1 00000000 00 0001 0
255 00 0 2 1 00000000 00 0000 0
1 00 0 0 0 00000000 00 0000 1
3 00 0 0 0 00000000 00 0000 0

//--- verilog.f
pibus_pkg.sv
bus_arbiter.sv
bus_timeout.sv
bus_cont.sv
bus_addr_decode.sv
pibus_top.sv
tb_pibus.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_pibus
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_pibus.sv
// needs pibus_input.txt in the run directory; one line per vector, held for its repeat count
`timescale 1ns/1ps

module tb_pibus;

   import pibus_pkg::*;

   typedef struct packed {
      logic [31:0]         count;   // cycles this line is held
      bus_req_t            req;
      logic                lock;
      opc_t                opc;
      ack_t                ack;
      addr_t               addr;
      bus_gnt_t            gnt;     // expected outputs from here on
      logic [N_SLAVES-1:0] sel;
      logic                tout;
   } vec_t;

   logic                clk = 1'b0;
   logic                rst_n;
   bus_req_t            req;
   bus_ctl_t            ctl;
   ack_t                ack;
   bus_gnt_t            gnt;
   logic [N_SLAVES-1:0] sel;
   logic                tout;

   vec_t vecs[$];
   int   total_cycles = 0;
   int   cycle_limit  = 50;   // raised once the vectors are loaded
   int   cycles       = 0;

   pibus_top pibus_top_i (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .ctl   (ctl),
      .ack   (ack),
      .gnt   (gnt),
      .sel   (sel),
      .tout  (tout)
   );

   always #5 clk = ~clk;

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic load_vectors();
      int          fd;
      int          code;
      string       line;
      int          f_cnt;
      logic [1:0]  f_req;
      logic        f_lock;
      logic [3:0]  f_opc;
      logic [2:0]  f_ack;
      logic [29:0] f_addr;
      logic [1:0]  f_gnt;
      logic [3:0]  f_sel;
      logic        f_tout;
      vec_t        v;
      fd = $fopen("pibus_input.txt", "r");
      if (fd == 0)
      begin
         stop_with_error("cannot open pibus_input.txt");
      end
      while ($fgets(line, fd) > 0)
      begin
         code = $sscanf(line, "%d %b %b %h %d %h %b %b %b", f_cnt, f_req, f_lock, f_opc,
                        f_ack, f_addr, f_gnt, f_sel, f_tout);
         if (code == 9)
         begin
            v.count = f_cnt;
            v.req   = f_req;
            v.lock  = f_lock;
            v.opc   = f_opc;
            v.ack   = f_ack;
            v.addr  = f_addr;   // top hex digits land on addr[0]
            v.gnt   = f_gnt;
            v.sel   = f_sel;
            v.tout  = f_tout;
            vecs.push_back(v);
            total_cycles += f_cnt;
         end
         else if (code > 0)
         begin
            stop_with_error({"malformed vector line: ", line});
         end
      end
      $fclose(fd);
      if (vecs.size() == 0)
      begin
         stop_with_error("no vectors found in pibus_input.txt");
      end
      cycle_limit = total_cycles + 50;
   endtask

   task automatic drive_inputs(input vec_t v);
      req      <= v.req;
      ctl.addr <= v.addr;
      ctl.opc  <= v.opc;
      ctl.lock <= v.lock;
      ctl.read <= 1'b1;   // direction not decoded by the controller
      ack      <= v.ack;
   endtask

   task automatic check_outputs(input vec_t v);
      a_gnt: assert (gnt === v.gnt)
      else
         stop_with_error($sformatf("ERROR at %0d ns: gnt expected %b, got %b",
                                   $time, v.gnt, gnt));
      a_sel: assert (sel === v.sel)
      else
         stop_with_error($sformatf("ERROR at %0d ns: sel expected %b, got %b",
                                   $time, v.sel, sel));
      a_tout: assert (tout === v.tout)
      else
         stop_with_error($sformatf("ERROR at %0d ns: tout expected %b, got %b",
                                   $time, v.tout, tout));
   endtask

   // run limit, counted from the end of reset
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         cycles <= cycles + 1;
         if (cycles >= cycle_limit)
         begin
            stop_with_error($sformatf("timeout after %0d cycles, vectors did not finish",
                                      cycles));
         end
      end
   end

   initial
   begin
      rst_n <= 1'b0;
      req   <= '0;
      ctl   <= '0;
      ack   <= '0;
      repeat (4) @(posedge clk);
      load_vectors();
      rst_n <= 1'b1;
      foreach (vecs[i])
      begin
         for (int r = 0; r < vecs[i].count; r++)
         begin
            @(posedge clk);
            drive_inputs(vecs[i]);
            #9;   // just before the next edge
            check_outputs(vecs[i]);
         end
      end
      $display("sim passed");
      $finish;
   end

endmodule

//--- pibus_top.sv
// controller and slave decoder only; masters, slaves and the data path sit outside
`timescale 1ns/1ps

module pibus_top (
   input  logic                           clk,
   input  logic                           rst_n,
   input  pibus_pkg::bus_req_t            req,
   input  pibus_pkg::bus_ctl_t            ctl,
   input  pibus_pkg::ack_t                ack,
   output pibus_pkg::bus_gnt_t            gnt,
   output logic [pibus_pkg::N_SLAVES-1:0] sel,
   output logic                           tout
);

   logic sel_en;   // registered in the controller

   bus_cont bus_cont_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (req),
      .ctl    (ctl),
      .ack    (ack),
      .gnt    (gnt),
      .sel_en (sel_en),
      .tout   (tout)
   );

   bus_addr_decode bus_addr_decode_i (
      .addr   (ctl.addr),
      .sel_en (sel_en),
      .sel    (sel)
   );

endmodule

//--- bus_addr_decode.sv
// four slaves on the top two address bits; sel is combinational, stable only once addr settles
`timescale 1ns/1ps

module bus_addr_decode (
   input  pibus_pkg::addr_t              addr,
   input  logic                          sel_en,
   output logic [pibus_pkg::N_SLAVES-1:0] sel
);

   import pibus_pkg::*;

   logic [SEL_W-1:0] slot;   // addressed slave

   assign slot = addr[0 +: SEL_W];   // addr[0] is the msb

   always_comb
   begin
      sel = '0;
      if (sel_en)
      begin
         sel[slot] = 1'b1;
      end
   end

   // every address hits exactly one slave when enabled
   always_comb
   begin
      a_sel_onehot: assert ($onehot0(sel) && ((sel != '0) == sel_en))
      else
         $error("slave select not one-hot: %b", sel);
   end

endmodule

//--- bus_cont.sv
// ack is sampled every cycle; gnt, sel_en and tout are registered and last one cycle each
`timescale 1ns/1ps

module bus_cont (
   input  logic                clk,
   input  logic                rst_n,
   input  pibus_pkg::bus_req_t req,
   input  pibus_pkg::bus_ctl_t ctl,
   input  pibus_pkg::ack_t     ack,
   output pibus_pkg::bus_gnt_t gnt,
   output logic                sel_en,
   output logic                tout
);

   import pibus_pkg::*;

   phase_t   phase;
   phase_t   phase_nxt;
   bus_gnt_t pick;         // arbiter choice this cycle
   bus_gnt_t gnt_nxt;
   logic     sel_en_nxt;
   logic     tout_nxt;
   logic     grant_en;     // arbitrate on the coming edge
   logic     busy;         // data phase in progress
   logic     expired;
   logic     any_req;
   logic     opc_nop;
   logic     locked_nop;

   assign any_req    = req.req0 | req.req1;
   assign opc_nop    = (ctl.opc == OPC_NOP);
   assign locked_nop = ctl.lock && opc_nop;
   assign busy       = (phase == PH_ADDRDATA) || (phase == PH_DATA);

   bus_arbiter bus_arbiter_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .grant_en (grant_en),
      .pick     (pick)
   );

   bus_timeout bus_timeout_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .busy    (busy),
      .expired (expired)
   );

   always_comb
   begin
      phase_nxt  = phase;
      gnt_nxt    = '0;
      sel_en_nxt = 1'b0;
      tout_nxt   = 1'b0;
      grant_en   = 1'b0;

      case (phase)
         PH_IDLE:
         begin
            grant_en = 1'b1;
         end

         PH_REQ:
         begin
            sel_en_nxt = !opc_nop;   // select only for a real transfer
            phase_nxt  = PH_ADDR;
         end

         PH_ADDR:
         begin
            if (opc_nop)
            begin
               if (!ctl.lock)
               begin
                  grant_en = 1'b1;   // bus released
               end
            end
            else if (ctl.lock)
            begin
               sel_en_nxt = (ack == ACK_RDY);
               phase_nxt  = PH_ADDRDATA;
            end
            else if (ack == ACK_RDY)
            begin
               grant_en = 1'b1;
            end
            else if (ack == ACK_ERR)
            begin
               phase_nxt = PH_IDLE;
            end
            else
            begin
               phase_nxt = PH_DATA;
            end
         end

         PH_ADDRDATA, PH_DATA:
         begin
            if ((ack == ACK_ERR) || expired)
            begin
               phase_nxt = PH_IDLE;   // abandon the transfer
               tout_nxt  = 1'b1;
            end
            else if (ack == ACK_RDY)
            begin
               if ((phase == PH_ADDRDATA) && locked_nop)
               begin
                  phase_nxt = PH_ADDR;   // master keeps the bus
               end
               else
               begin
                  grant_en = 1'b1;
               end
            end
         end

         default:
         begin
            phase_nxt = PH_IDLE;
         end
      endcase

      // new tenure, or idle if nobody asks
      if (grant_en)
      begin
         phase_nxt = any_req ? PH_REQ : PH_IDLE;
         gnt_nxt   = pick;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         phase  <= PH_IDLE;
         gnt    <= '0;
         sel_en <= 1'b0;
         tout   <= 1'b0;
      end
      else
      begin
         phase  <= phase_nxt;
         gnt    <= gnt_nxt;
         sel_en <= sel_en_nxt;
         tout   <= tout_nxt;
      end
   end

   // a grant is seen exactly while the single REQ cycle lasts
   a_gnt_in_req: assert property (@(posedge clk) disable iff (!rst_n)
      (gnt != '0) == (phase == PH_REQ));

   a_gnt_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      (gnt != '0) |=> (gnt == '0));

endmodule

//--- bus_timeout.sv
// busy must drop to clear the count; expired fires on the TOUT_LIMIT-th consecutive busy cycle
`timescale 1ns/1ps

module bus_timeout (
   input  logic clk,
   input  logic rst_n,
   input  logic busy,
   output logic expired
);

   import pibus_pkg::*;

   logic [7:0] cnt;   // busy cycles already completed

   // current cycle is the last one allowed
   assign expired = busy && (cnt == 8'(TOUT_LIMIT - 1));

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cnt <= '0;
      end
      else if (!busy || expired)
      begin
         cnt <= '0;   // restart after idle or expiry
      end
      else
      begin
         cnt <= cnt + 8'd1;
      end
   end

   // the watchdog never fires twice in a row
   a_expired_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      expired |=> !expired);

endmodule

//--- bus_arbiter.sv
// two masters only; pick is combinational and valid only while grant_en is asserted
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                clk,
   input  logic                rst_n,
   input  pibus_pkg::bus_req_t req,
   input  logic                grant_en,
   output pibus_pkg::bus_gnt_t pick
);

   import pibus_pkg::*;

   logic last_m0;   // master 0 won the last accepted grant
   logic any_req;

   assign any_req = req.req0 | req.req1;

   // alternate on contention, otherwise the lone requester wins
   always_comb
   begin
      pick = '0;
      if (req.req0 && req.req1)
      begin
         pick.gnt0 = !last_m0;
         pick.gnt1 = last_m0;
      end
      else
      begin
         pick.gnt0 = req.req0;
         pick.gnt1 = req.req1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         last_m0 <= 1'b0;   // master 0 goes first
      end
      else if (grant_en && any_req)
      begin
         last_m0 <= pick.gnt0;   // remember who got the bus
      end
   end

   // only one master may drive the bus, and only one that asked for it
   a_pick_valid: assert property (@(posedge clk) disable iff (!rst_n)
      grant_en |-> !(pick.gnt0 && pick.gnt1)
                   && (!pick.gnt0 || req.req0)
                   && (!pick.gnt1 || req.req1));

endmodule

//--- pibus_pkg.sv
// ack codes other than wait, ready and error are taken as wait; address bit 0 is the msb
package pibus_pkg;

   // slave acknowledge codes
   typedef logic [2:0] ack_t;

   localparam ack_t ACK_WAT = 3'd1;   // slave still busy
   localparam ack_t ACK_RDY = 3'd2;   // transfer done
   localparam ack_t ACK_ERR = 3'd3;   // slave rejected the transfer

   // transfer opcode, anything but nop is a real transfer
   typedef logic [3:0] opc_t;

   localparam opc_t OPC_NOP = 4'd0;

   typedef logic [0:29] addr_t;   // bit 0 is the msb

   typedef enum logic [2:0] {
      PH_IDLE     = 3'd0,
      PH_REQ      = 3'd1,
      PH_ADDR     = 3'd2,
      PH_ADDRDATA = 3'd3,   // address of the next transfer overlaps data
      PH_DATA     = 3'd4
   } phase_t;

   typedef struct packed {
      logic req0;
      logic req1;
   } bus_req_t;

   typedef struct packed {
      logic gnt0;
      logic gnt1;
   } bus_gnt_t;

   // master side control word
   typedef struct packed {
      addr_t addr;
      opc_t  opc;
      logic  lock;   // overlap the next address with this data phase
      logic  read;
   } bus_ctl_t;

   localparam int TOUT_LIMIT = 255;   // busy cycles before the watchdog fires
   localparam int N_SLAVES   = 4;
   localparam int SEL_W      = $clog2(N_SLAVES);   // address bits used for the select

endpackage
